// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_ex_latch_queue
FILELIST  = sim.f
RUN_FLAGS = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/ex_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_issue import latch_pkg::*; #(
    parameter int OPS    = 2,
    parameter int TAG_W  = 4,
    parameter int DATA_W = 16
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   clr,
    input  logic                                                   empty,
    input  logic [n_width(TAG_W)+m_width(OPS, TAG_W, DATA_W)-1:0] head,
    input  logic                                                   ex_ready,
    output logic                                                   rd,
    output logic                                                   ex_valid,
    output op_e                                                    ex_op,
    output logic [TAG_W-1:0]                                       ex_dest,
    output logic [OPS*DATA_W-1:0]                                  ex_src_val
);

    localparam int M_W   = m_width(OPS, TAG_W, DATA_W);
    localparam int OPD_W = m_width(1, TAG_W, DATA_W);

    logic [OPS-1:0]        head_rdy;
    logic [OPS*DATA_W-1:0] head_val;
    op_e                   head_op;
    logic [TAG_W-1:0]      head_dest;

    // fixed part sits above the operands
    assign head_op   = op_e'(head[M_W+TAG_W +: OP_W]);
    assign head_dest = head[M_W +: TAG_W];

    for (genvar i = 0; i < OPS; i++) begin : g_opd
        assign head_rdy[i]                  = head[i*OPD_W + OPD_W - 1];
        assign head_val[i*DATA_W +: DATA_W] = head[i*OPD_W +: DATA_W];
    end

    // pull the head when all operands are in and the register frees up
    assign rd = !empty && (&head_rdy) && (!ex_valid || ex_ready);

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            ex_valid <= 1'b0;
        end else if (rd) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    // held under back-pressure since rd stays low
    always_ff @(posedge clk) begin
        if (rd) begin
            ex_op      <= head_op;
            ex_dest    <= head_dest;
            ex_src_val <= head_val;
        end
    end

endmodule

`default_nettype wire

// ==== design/latch_pkg.sv ====
`default_nettype none

package latch_pkg;

    // execute opcode field width
    localparam int OP_W = 3;

    // operations carried to execute, not evaluated here
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_PASS = 3'd5
    } op_e;

    // modifiable part: per operand {ready, tag, value}
    function automatic int m_width(input int ops, input int tag_w, input int data_w);
        return ops * (1 + tag_w + data_w);
    endfunction

    // fixed part: {opcode, destination tag}
    function automatic int n_width(input int tag_w);
        return OP_W + tag_w;
    endfunction

endpackage

`default_nettype wire

// ==== design/mem_ex_latch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ex_latch_queue import latch_pkg::*; #(
    parameter int OPS      = 2,
    parameter int TAG_W    = 4,
    parameter int DATA_W   = 16,
    parameter int Q_LENGTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    input  logic                  mem_wr,
    input  op_e                   mem_op,
    input  logic [TAG_W-1:0]      mem_dest,
    input  logic [OPS*TAG_W-1:0]  mem_src_tag,
    input  logic [OPS*DATA_W-1:0] mem_src_val,
    input  logic [OPS-1:0]        mem_src_rdy,
    input  logic                  bcast_valid,
    input  logic [TAG_W-1:0]      bcast_tag,
    input  logic [DATA_W-1:0]     bcast_data,
    input  logic                  ex_ready,
    output logic                  full,
    output logic                  empty,
    output logic                  ex_valid,
    output op_e                   ex_op,
    output logic [TAG_W-1:0]      ex_dest,
    output logic [OPS*DATA_W-1:0] ex_src_val
);

    localparam int M_W   = m_width(OPS, TAG_W, DATA_W);
    localparam int N_W   = n_width(TAG_W);
    localparam int OPD_W = m_width(1, TAG_W, DATA_W);

    logic [M_W-1:0]          m_din;
    logic [N_W-1:0]          n_din;
    logic [Q_LENGTH*M_W-1:0] old_m_vector;
    logic [Q_LENGTH*M_W-1:0] new_m_vector;
    logic [Q_LENGTH-1:0]     modify_vector;
    logic [N_W+M_W-1:0]      dout;
    logic                    rd;

    // operand i packed as {ready, tag, value} at slice i
    for (genvar i = 0; i < OPS; i++) begin : g_pack
        assign m_din[i*OPD_W +: OPD_W] = {mem_src_rdy[i],
                                          mem_src_tag[i*TAG_W +: TAG_W],
                                          mem_src_val[i*DATA_W +: DATA_W]};
    end

    assign n_din = {mem_op, mem_dest};

    queue_nm #(
        .OPS      (OPS),
        .TAG_W    (TAG_W),
        .DATA_W   (DATA_W),
        .Q_LENGTH (Q_LENGTH)
    ) queue_nm_i (
        .clk           (clk),
        .rst           (rst),
        .clr           (clr),
        .wr            (mem_wr),
        .rd            (rd),
        .m_din         (m_din),
        .n_din         (n_din),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    operand_wakeup #(
        .OPS      (OPS),
        .TAG_W    (TAG_W),
        .DATA_W   (DATA_W),
        .Q_LENGTH (Q_LENGTH)
    ) operand_wakeup_i (
        .bcast_valid   (bcast_valid),
        .bcast_tag     (bcast_tag),
        .bcast_data    (bcast_data),
        .old_m_vector  (old_m_vector),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector)
    );

    ex_issue #(
        .OPS    (OPS),
        .TAG_W  (TAG_W),
        .DATA_W (DATA_W)
    ) ex_issue_i (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .empty      (empty),
        .head       (dout),
        .ex_ready   (ex_ready),
        .rd         (rd),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_dest    (ex_dest),
        .ex_src_val (ex_src_val)
    );

endmodule

`default_nettype wire

// ==== design/operand_wakeup.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_wakeup import latch_pkg::*; #(
    parameter int OPS      = 2,
    parameter int TAG_W    = 4,
    parameter int DATA_W   = 16,
    parameter int Q_LENGTH = 4
) (
    input  logic                                          bcast_valid,
    input  logic [TAG_W-1:0]                                bcast_tag,
    input  logic [DATA_W-1:0]                               bcast_data,
    input  logic [Q_LENGTH*m_width(OPS, TAG_W, DATA_W)-1:0] old_m_vector,
    output logic [Q_LENGTH*m_width(OPS, TAG_W, DATA_W)-1:0] new_m_vector,
    output logic [Q_LENGTH-1:0]                             modify_vector
);

    localparam int M_W   = m_width(OPS, TAG_W, DATA_W);
    // one operand: {ready, tag, value}
    localparam int OPD_W = m_width(1, TAG_W, DATA_W);

    // one match bit per operand per slot
    logic [Q_LENGTH*OPS-1:0] match;

    for (genvar k = 0; k < Q_LENGTH; k++) begin : g_slot
        for (genvar i = 0; i < OPS; i++) begin : g_opd
            localparam int BASE = k*M_W + i*OPD_W;

            logic [OPD_W-1:0] old_opd;
            logic             opd_rdy;
            logic [TAG_W-1:0] opd_tag;

            assign old_opd = old_m_vector[BASE +: OPD_W];
            assign opd_rdy = old_opd[OPD_W-1];
            assign opd_tag = old_opd[DATA_W +: TAG_W];

            // only waiting operands listen
            assign match[k*OPS + i] = bcast_valid && !opd_rdy && (opd_tag == bcast_tag);

            assign new_m_vector[BASE +: OPD_W] = match[k*OPS + i] ?
                                                 {1'b1, opd_tag, bcast_data} : old_opd;
        end

        assign modify_vector[k] = |match[k*OPS +: OPS];
    end

endmodule

`default_nettype wire

// ==== design/queue_nm.sv ====
`timescale 1ns/1ps
`default_nettype none

module queue_nm import latch_pkg::*; #(
    parameter int OPS      = 2,
    parameter int TAG_W    = 4,
    parameter int DATA_W   = 16,
    parameter int Q_LENGTH = 4
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          clr,
    input  logic                                          wr,
    input  logic                                          rd,
    input  logic [m_width(OPS, TAG_W, DATA_W)-1:0]          m_din,
    input  logic [n_width(TAG_W)-1:0]                       n_din,
    input  logic [Q_LENGTH*m_width(OPS, TAG_W, DATA_W)-1:0] new_m_vector,
    input  logic [Q_LENGTH-1:0]                             modify_vector,
    output logic                                          full,
    output logic                                          empty,
    output logic [Q_LENGTH*m_width(OPS, TAG_W, DATA_W)-1:0] old_m_vector,
    output logic [n_width(TAG_W)+m_width(OPS, TAG_W, DATA_W)-1:0] dout
);

    localparam int M_W   = m_width(OPS, TAG_W, DATA_W);
    localparam int N_W   = n_width(TAG_W);
    localparam int PTR_W = (Q_LENGTH > 1) ? $clog2(Q_LENGTH) : 1;
    localparam int CNT_W = $clog2(Q_LENGTH + 1);

    // slot storage
    logic [M_W-1:0] m_mem [Q_LENGTH];
    logic [N_W-1:0] n_mem [Q_LENGTH];

    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    logic [CNT_W-1:0]    count;
    logic [Q_LENGTH-1:0] occ;
    logic [Q_LENGTH-1:0] occ_nxt;

    logic do_wr;
    logic do_rd;

    // wrap at Q_LENGTH, also for non power of two depths
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(Q_LENGTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(Q_LENGTH));
    assign empty = (count == '0);

    // a write into a full queue is dropped even with a read
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_comb begin
        occ_nxt = occ;
        if (do_rd) begin
            occ_nxt[head] = 1'b0;
        end
        if (do_wr) begin
            occ_nxt[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            occ   <= '0;
        end else begin
            occ   <= occ_nxt;
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
            if (do_wr) begin
                tail <= ptr_inc(tail);
            end
            if (do_rd) begin
                head <= ptr_inc(head);
            end
        end
    end

    // in-place wakeup of occupied slots, then the new entry
    // the tail slot is never occupied on a write, so the two never collide
    always_ff @(posedge clk) begin
        for (int k = 0; k < Q_LENGTH; k++) begin
            if (occ[k] && modify_vector[k]) begin
                m_mem[k] <= new_m_vector[k*M_W +: M_W];
            end
        end
        if (do_wr) begin
            m_mem[tail] <= m_din;
            n_mem[tail] <= n_din;
        end
    end

    for (genvar k = 0; k < Q_LENGTH; k++) begin : g_old
        assign old_m_vector[k*M_W +: M_W] = m_mem[k];
    end

    // head entry, fixed part on top
    assign dout = {n_mem[head], m_mem[head]};

endmodule

`default_nettype wire

// ==== sim.f ====
design/latch_pkg.sv
design/queue_nm.sv
design/operand_wakeup.sv
design/ex_issue.sv
design/mem_ex_latch_queue.sv
tests/mem_ex_latch_queue_asserts.sv
tests/tb_mem_ex_latch_queue.sv

// ==== tests/mem_ex_latch_queue_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ex_latch_queue_asserts import latch_pkg::*; #(
    parameter int OPS    = 2,
    parameter int TAG_W  = 4,
    parameter int DATA_W = 16
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  clr,
    input logic                  ex_ready,
    input logic                  full,
    input logic                  empty,
    input logic                  ex_valid,
    input op_e                   ex_op,
    input logic [TAG_W-1:0]      ex_dest,
    input logic [OPS*DATA_W-1:0] ex_src_val
);

    a_full_empty: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else $error("full and empty are high together");

    a_flush_clears: assert property (@(posedge clk) (rst || clr) |=> !ex_valid)
        else $error("ex_valid is high the cycle after rst or clr");

    // stalled execute register keeps its entry
    a_stall_hold: assert property (@(posedge clk)
        (ex_valid && !ex_ready && !rst && !clr) |=>
        (ex_valid && $stable(ex_op) && $stable(ex_dest) && $stable(ex_src_val)))
        else $error("execute outputs changed under back-pressure");

endmodule

bind mem_ex_latch_queue mem_ex_latch_queue_asserts #(
    .OPS    (OPS),
    .TAG_W  (TAG_W),
    .DATA_W (DATA_W)
) mem_ex_latch_queue_asserts_i (
    .clk        (clk),
    .rst        (rst),
    .clr        (clr),
    .ex_ready   (ex_ready),
    .full       (full),
    .empty      (empty),
    .ex_valid   (ex_valid),
    .ex_op      (ex_op),
    .ex_dest    (ex_dest),
    .ex_src_val (ex_src_val)
);

`default_nettype wire

// ==== tests/tb_mem_ex_latch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ex_latch_queue
    import latch_pkg::*;
();

    localparam int OPS      = 2;
    localparam int TAG_W    = 4;
    localparam int DATA_W   = 16;
    localparam int Q_LENGTH = 4;
    localparam int VEC_W    = OPS * DATA_W;
    // six tests of about 15 cycles each plus reset, with a wide margin
    localparam int MAX_CYCLES = 400;

    logic                 clk;
    logic                 rst;
    logic                 clr;
    logic                 mem_wr;
    op_e                  mem_op;
    logic [TAG_W-1:0]     mem_dest;
    logic [OPS*TAG_W-1:0] mem_src_tag;
    logic [VEC_W-1:0]     mem_src_val;
    logic [OPS-1:0]       mem_src_rdy;
    logic                 bcast_valid;
    logic [TAG_W-1:0]     bcast_tag;
    logic [DATA_W-1:0]    bcast_data;
    logic                 ex_ready;
    logic                 full;
    logic                 empty;
    logic                 ex_valid;
    op_e                  ex_op;
    logic [TAG_W-1:0]     ex_dest;
    logic [VEC_W-1:0]     ex_src_val;

    // reference model: waiting entries plus the execute register
    op_e                  q_op   [Q_LENGTH];
    logic [TAG_W-1:0]     q_dest [Q_LENGTH];
    logic [OPS*TAG_W-1:0] q_tag  [Q_LENGTH];
    logic [VEC_W-1:0]     q_val  [Q_LENGTH];
    logic [OPS-1:0]       q_rdy  [Q_LENGTH];
    int                   qn = 0;
    logic                 exv_m = 1'b0;
    op_e                  exop_m;
    logic [TAG_W-1:0]     exdest_m;
    logic [VEC_W-1:0]     exval_m;

    // destinations in the order they left the execute register
    logic [TAG_W-1:0] log_dest [64];
    int               log_n = 0;

    int op_errors  = 0;
    int vec_errors = 0;
    int bit_errors = 0;
    int cycles     = 0;

    mem_ex_latch_queue #(
        .OPS      (OPS),
        .TAG_W    (TAG_W),
        .DATA_W   (DATA_W),
        .Q_LENGTH (Q_LENGTH)
    ) mem_ex_latch_queue_i (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .mem_wr      (mem_wr),
        .mem_op      (mem_op),
        .mem_dest    (mem_dest),
        .mem_src_tag (mem_src_tag),
        .mem_src_val (mem_src_val),
        .mem_src_rdy (mem_src_rdy),
        .bcast_valid (bcast_valid),
        .bcast_tag   (bcast_tag),
        .bcast_data  (bcast_data),
        .ex_ready    (ex_ready),
        .full        (full),
        .empty       (empty),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_dest     (ex_dest),
        .ex_src_val  (ex_src_val)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_op(input op_e got, input op_e exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s: got %s, expected %s", $time, what, got.name(), exp.name());
            op_errors++;
        end
    endtask

    task automatic check_vec(input logic [VEC_W-1:0] got, input logic [VEC_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s: got %0h, expected %0h", $time, what, got, exp);
            vec_errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s: got %b, expected %b", $time, what, got, exp);
            bit_errors++;
        end
    endtask

    // only operands still waiting listen to the broadcast
    task automatic wake_model(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
        for (int j = 0; j < qn; j++) begin
            for (int i = 0; i < OPS; i++) begin
                if (!q_rdy[j][i] && q_tag[j][i*TAG_W +: TAG_W] == tag) begin
                    q_rdy[j][i] = 1'b1;
                    q_val[j][i*DATA_W +: DATA_W] = data;
                end
            end
        end
    endtask

    task automatic step_model();
        logic rd_m;
        logic wr_ok;
        rd_m  = (qn > 0) && (&q_rdy[0]) && (!exv_m || ex_ready);
        wr_ok = mem_wr && (qn < Q_LENGTH);
        if (bcast_valid) begin
            wake_model(bcast_tag, bcast_data);
        end
        if (rd_m) begin
            exv_m    = 1'b1;
            exop_m   = q_op[0];
            exdest_m = q_dest[0];
            exval_m  = q_val[0];
            for (int j = 0; j < qn - 1; j++) begin
                q_op[j]   = q_op[j+1];
                q_dest[j] = q_dest[j+1];
                q_tag[j]  = q_tag[j+1];
                q_val[j]  = q_val[j+1];
                q_rdy[j]  = q_rdy[j+1];
            end
            qn--;
        end else if (ex_ready) begin
            exv_m = 1'b0;
        end
        // new entry lands after the broadcast, so it misses it
        if (wr_ok) begin
            q_op[qn]   = mem_op;
            q_dest[qn] = mem_dest;
            q_tag[qn]  = mem_src_tag;
            q_val[qn]  = mem_src_val;
            q_rdy[qn]  = mem_src_rdy;
            qn++;
        end
    endtask

    always @(posedge clk) begin
        if (rst || clr) begin
            qn    = 0;
            exv_m = 1'b0;
        end else begin
            step_model();
        end
    end

    // compare against the model half a cycle after each edge
    always @(negedge clk) begin
        if (!rst) begin
            check_bit(full, qn == Q_LENGTH, "full flag");
            check_bit(empty, qn == 0, "empty flag");
            check_bit(ex_valid, exv_m, "ex_valid");
            if (exv_m) begin
                check_op(ex_op, exop_m, "ex_op");
                check_vec(VEC_W'(ex_dest), VEC_W'(exdest_m), "ex_dest");
                check_vec(ex_src_val, exval_m, "ex_src_val");
            end
            if (ex_valid && ex_ready && log_n < 64) begin
                log_dest[log_n] = ex_dest;
                log_n++;
            end
        end
    end

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    function automatic logic [VEC_W-1:0] rand_vals();
        logic [VEC_W-1:0] v;
        for (int i = 0; i < OPS; i++) begin
            v[i*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
        return v;
    endfunction

    task automatic write_entry(input op_e op, input logic [TAG_W-1:0] dest,
                               input logic [OPS*TAG_W-1:0] tags, input logic [VEC_W-1:0] vals,
                               input logic [OPS-1:0] rdy);
        mem_op      = op;
        mem_dest    = dest;
        mem_src_tag = tags;
        mem_src_val = vals;
        mem_src_rdy = rdy;
        mem_wr      = 1'b1;
        tick(1);
        mem_wr = 1'b0;
    endtask

    task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
        bcast_tag   = tag;
        bcast_data  = data;
        bcast_valid = 1'b1;
        tick(1);
        bcast_valid = 1'b0;
    endtask

    task automatic wait_issue();
        while (!ex_valid) begin
            tick(1);
        end
    endtask

    task automatic wait_drain();
        while (!(empty && !ex_valid)) begin
            tick(1);
        end
    endtask

    // destinations leave as first, first+1, ... starting at log index start
    task automatic check_order(input int start, input int n, input int first);
        check_vec(VEC_W'(log_n - start), VEC_W'(n), "number of issued entries");
        for (int k = 0; k < n; k++) begin
            check_vec(VEC_W'(log_dest[start + k]), VEC_W'(first + k), "issue order");
        end
    endtask

    task automatic pass_in_order();
        int start;
        start    = log_n;
        ex_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            write_entry(op_e'(3'(k)), TAG_W'(k + 1), '0, rand_vals(), '1);
        end
        wait_drain();
        check_order(start, 4, 1);
    endtask

    task automatic wake_operands();
        logic [VEC_W-1:0]  exp;
        logic [DATA_W-1:0] d5;
        logic [DATA_W-1:0] d6;
        int                start;
        start    = log_n;
        ex_ready = 1'b1;
        exp      = rand_vals();
        d5       = DATA_W'($urandom);
        d6       = DATA_W'($urandom);
        write_entry(OP_SUB, 4'd7, {4'd6, 4'd5}, exp, 2'b00);
        broadcast(4'd9, d5);
        tick(2);
        check_bit(ex_valid, 1'b0, "issue before wakeup");
        broadcast(4'd5, d5);
        tick(2);
        check_bit(ex_valid, 1'b0, "issue with operand 1 still waiting");
        broadcast(4'd6, d6);
        wait_issue();
        exp[0 +: DATA_W]      = d5;
        exp[DATA_W +: DATA_W] = d6;
        check_op(ex_op, OP_SUB, "woken opcode");
        check_vec(ex_src_val, exp, "woken operand values");
        wait_drain();
        check_order(start, 1, 7);
    endtask

    task automatic fill_and_drop();
        int start;
        start    = log_n;
        ex_ready = 1'b0;
        // head waits on tag 9 so nothing leaves
        write_entry(OP_AND, '0, {4'd0, 4'd9}, rand_vals(), 2'b10);
        for (int k = 1; k < Q_LENGTH; k++) begin
            write_entry(OP_OR, TAG_W'(k), '0, rand_vals(), '1);
        end
        check_bit(full, 1'b1, "full after Q_LENGTH writes");
        write_entry(OP_XOR, 4'hc, '0, rand_vals(), '1);
        check_bit(full, 1'b1, "full after dropped write");
        ex_ready = 1'b1;
        broadcast(4'd9, DATA_W'($urandom));
        wait_drain();
        check_order(start, Q_LENGTH, 0);
    endtask

    task automatic hold_under_stall();
        logic [VEC_W-1:0] v0;
        int               start;
        start    = log_n;
        ex_ready = 1'b0;
        v0       = rand_vals();
        write_entry(OP_PASS, 4'd8, '0, v0, '1);
        write_entry(OP_ADD, 4'd9, '0, rand_vals(), '1);
        write_entry(OP_SUB, 4'd10, '0, rand_vals(), '1);
        wait_issue();
        tick(4);
        check_bit(ex_valid, 1'b1, "ex_valid under stall");
        check_op(ex_op, OP_PASS, "held opcode");
        check_vec(VEC_W'(ex_dest), VEC_W'(8), "held destination");
        check_vec(ex_src_val, v0, "held operand values");
        check_bit(empty, 1'b0, "queue kept its entries");
        ex_ready = 1'b1;
        wait_drain();
        check_order(start, 3, 8);
    endtask

    task automatic flush_queue();
        int start;
        ex_ready = 1'b0;
        for (int k = 1; k <= 3; k++) begin
            write_entry(OP_AND, TAG_W'(k), '0, rand_vals(), '1);
        end
        wait_issue();
        clr = 1'b1;
        tick(1);
        clr = 1'b0;
        check_bit(empty, 1'b1, "empty after clr");
        check_bit(ex_valid, 1'b0, "ex_valid after clr");
        start    = log_n;
        ex_ready = 1'b1;
        write_entry(OP_OR, 4'd5, '0, rand_vals(), '1);
        write_entry(OP_XOR, 4'd6, '0, rand_vals(), '1);
        wait_drain();
        check_order(start, 2, 5);
    endtask

    task automatic write_during_broadcast();
        logic [VEC_W-1:0]  exp;
        logic [DATA_W-1:0] d;
        int                start;
        start    = log_n;
        ex_ready = 1'b1;
        exp      = rand_vals();
        d        = DATA_W'($urandom);
        bcast_tag   = 4'd3;
        bcast_data  = DATA_W'($urandom);
        bcast_valid = 1'b1;
        write_entry(OP_XOR, 4'd11, {4'd0, 4'd3}, exp, 2'b10);
        bcast_valid = 1'b0;
        tick(3);
        check_bit(ex_valid, 1'b0, "same-cycle broadcast woke the new entry");
        check_bit(empty, 1'b0, "entry still waiting");
        broadcast(4'd3, d);
        wait_issue();
        exp[0 +: DATA_W] = d;
        check_vec(ex_src_val, exp, "value from later broadcast");
        wait_drain();
        check_order(start, 1, 11);
    endtask

    initial begin
        int total;
        void'($urandom(32'hf2b53526));
        rst         = 1'b1;
        clr         = 1'b0;
        mem_wr      = 1'b0;
        mem_op      = OP_ADD;
        mem_dest    = '0;
        mem_src_tag = '0;
        mem_src_val = '0;
        mem_src_rdy = '0;
        bcast_valid = 1'b0;
        bcast_tag   = '0;
        bcast_data  = '0;
        ex_ready    = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        pass_in_order();
        wake_operands();
        fill_and_drop();
        hold_under_stall();
        flush_queue();
        write_during_broadcast();
        tick(2);
        total = op_errors + vec_errors + bit_errors;
        $display("Checks done: %0d opcode, %0d vector, %0d flag errors",
                 op_errors, vec_errors, bit_errors);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
